// File: compile.f
verilog/pancal_types_pkg.sv
verilog/pancal_map_pkg.sv
verilog/pancal_regfile.sv
verilog/wb_arbiter.sv
verilog/panel_proc.sv
verilog/calendar_rtc.sv
verilog/io_pancal.sv
verification/tb_clock_gen.sv
verification/tb_io_pancal.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the io_pancal testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir
exe=tb_io_pancal_sim

verilator --binary --timing --assert -f compile.f --top-module tb_io_pancal \
   -Mdir "$obj" -o "$exe"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$obj/$exe" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$log"; then
   echo "Simulation reported failures"
   exit 1
fi
if ! grep -q "Done: no errors" "$log"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 2
) (
   output logic ck,
   output logic arst_n
);

   // Free running clock
   initial begin
      ck = 1'b0;
      forever #(period_ns / 2) ck = ~ck;
   end

   // Reset from time zero, released just after an edge
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge ck);
      #5 arst_n = 1'b1;
   end

endmodule

// File: verification/tb_io_pancal.sv
`timescale 1ns/100ps

module tb_io_pancal
   import pancal_types_pkg::*, pancal_map_pkg::*;
();

   localparam int ticks     = 4;
   localparam int n_rows    = 21;
   localparam int osc_edges = 246;
   // Each oscillator edge takes four clocks plus the settle wait
   localparam int limit_cycles = n_rows * 200 + osc_edges * 4 + 50;

   // Row kinds
   localparam int chk_none = 0;
   localparam int chk_disp = 1;
   localparam int chk_stat = 2;
   localparam int chk_msg  = 3;
   localparam int chk_cal  = 4;
   localparam int chk_bus  = 5;
   localparam int act_osc  = 6;

   logic       ck;
   logic       arst_n;
   byte_t      pa;
   logic       emp_n;
   logic       ful_n;
   logic       val;
   logic       rmm_n;
   logic       panosc;
   logic       epans;
   word_t      idb;
   disp_t      dp_n;
   logic [1:0] stat_4_3;

   // Stimulus table with one command per row
   byte_t row_cmd [n_rows];
   logic  row_has_data [n_rows];
   byte_t row_data [n_rows];
   int    row_kind [n_rows];
   int    row_exp [n_rows];
   int    n_used;

   byte_t       fifo_q [$];
   logic [31:0] lfsr;
   int          edges_total;
   int          checks;
   int          errors;
   logic        saw_reading;

   tb_clock_gen #(.period_ns(40), .reset_cycles(2)) i_clock (.ck(ck), .arst_n(arst_n));

   io_pancal #(.ticks_per_sec(ticks)) i_dut (
      .ck(ck), .arst_n(arst_n),
      .pa(pa), .emp_n(emp_n), .ful_n(ful_n), .val(val), .rmm_n(rmm_n),
      .panosc(panosc), .epans(epans), .idb(idb), .dp_n(dp_n), .stat_4_3(stat_4_3)
   );

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_byte(output byte_t b);
      b = '0;
      for (int k = 0; k < 8; k++) begin
         lfsr = lfsr_next(lfsr);
         b    = {b[6:0], lfsr[0]};
      end
   endtask

   // Time of day as the calendar should hold it after a number of edges
   function automatic int cal_value(input int addr, input int edges);
      int secs;
      secs = edges / ticks;
      case (addr)
         12:      cal_value = secs % 60;
         13:      cal_value = (secs / 60) % 60;
         14:      cal_value = (secs / 3600) % 24;
         default: cal_value = (secs / 86400) % 256;
      endcase
   endfunction

   task automatic expect_equal(input string what, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   task automatic add_row(input logic [1:0] op, input logic [4:0] low, input logic with_data,
                          input int kind, input int exp);
      byte_t d;
      d = '0;
      if (with_data) begin
         take_byte(d);
      end
      row_cmd[n_used]      = {op, 1'b0, low};
      row_has_data[n_used] = with_data;
      row_data[n_used]     = d;
      row_kind[n_used]     = kind;
      row_exp[n_used]      = exp;
      n_used++;
   endtask

   task automatic build_table();
      byte_t d3;
      byte_t d7;
      byte_t d11;
      add_row(op_disp, 5'h15, 1'b0, chk_disp, 'h15);
      add_row(op_disp, 5'h0a, 1'b0, chk_disp, 'h0a);
      add_row(op_stat, 5'h1b, 1'b0, chk_stat, 'h1b);
      add_row(op_wreg, 5'd3, 1'b1, chk_none, 0);
      d3 = row_data[n_used - 1];
      add_row(op_wreg, 5'd7, 1'b1, chk_none, 0);
      d7 = row_data[n_used - 1];
      add_row(op_rreg, 5'd3, 1'b0, chk_msg, d3);
      add_row(op_rreg, 5'd7, 1'b0, chk_msg, d7);
      add_row(op_wreg, 5'd11, 1'b1, chk_none, 0);
      d11 = row_data[n_used - 1];
      add_row(op_rreg, 5'd11, 1'b0, chk_msg, d11);
      // Panel write into calendar space is dropped
      add_row(op_wreg, 5'd12, 1'b1, chk_none, 0);
      add_row(op_rreg, 5'd12, 1'b0, chk_cal, 12);
      add_row(op_disp, 5'd0, 1'b0, act_osc, osc_edges);
      add_row(op_rreg, 5'd12, 1'b0, chk_cal, 12);
      add_row(op_wreg, 5'd13, 1'b1, chk_none, 0);
      add_row(op_rreg, 5'd13, 1'b0, chk_cal, 13);
      add_row(op_rreg, 5'd14, 1'b0, chk_cal, 14);
      add_row(op_rreg, 5'd15, 1'b0, chk_cal, 15);
      // Panel byte survives the calendar posts
      add_row(op_rreg, 5'd3, 1'b0, chk_msg, d3);
      // Bus rows carry {ful_n, val} as expected value
      add_row(op_stat, 5'h06, 1'b0, chk_bus, 'b01);
      add_row(op_stat, 5'h19, 1'b0, chk_bus, 'b10);
      add_row(op_disp, 5'h1f, 1'b0, chk_disp, 'h1f);
   endtask

   // FIFO model pops on the edge after the read strobe
   always begin
      @(negedge ck);
      if (rmm_n === 1'b0) begin
         @(posedge ck);
         #5;
         assert (fifo_q.size() != 0) else begin
            errors++;
            $display("FIFO read strobe at %0t while the FIFO model was empty", $time);
         end
         if (fifo_q.size() != 0) begin
            pa = fifo_q.pop_front();
         end
         emp_n = (fifo_q.size() != 0);
         // Strobe lasts one cycle
         expect_equal("rmm_n after strobe", rmm_n, 1);
      end
   end

   task automatic drive_osc(input int n);
      for (int e = 0; e < n; e++) begin
         panosc = 1'b1;
         repeat (2) @(posedge ck);
         #5;
         panosc = 1'b0;
         repeat (2) @(posedge ck);
         #5;
      end
      edges_total += n;
      // Last post has to reach the register file
      repeat (50) @(posedge ck);
   endtask

   task automatic apply_row(input int i);
      if (row_kind[i] == act_osc) begin
         drive_osc(row_exp[i]);
      end else begin
         fifo_q.push_back(row_cmd[i]);
         if (row_has_data[i]) begin
            fifo_q.push_back(row_data[i]);
         end
         emp_n = 1'b1;
      end
   endtask

   // Queue drained and panel idle as seen mid-cycle
   // Also notes whether a read cycle showed up on idb meanwhile
   task automatic wait_idle();
      saw_reading = 1'b0;
      do begin
         @(negedge ck);
         if (idb[13] === 1'b1) begin
            saw_reading = 1'b1;
         end
      end while (fifo_q.size() != 0 || idb[15] !== 1'b0);
   endtask

   task automatic check_bus(input logic f, input logic v, input logic [3:0] st);
      @(posedge ck);
      #5;
      ful_n = f;
      val   = v;
      epans = 1'b1;
      @(negedge ck);
      expect_equal("idb with epans high", idb, 0);
      @(posedge ck);
      #5;
      epans = 1'b0;
      @(negedge ck);
      expect_equal("idb ful_n bit", idb[14], f);
      expect_equal("idb val bit", idb[12], v);
      expect_equal("idb status bits", idb[11:8], st);
      expect_equal("idb busy and reading", {idb[15], idb[13]}, 0);
   endtask

   task automatic check_row(input int i);
      disp_t want_disp;
      want_disp = ~row_exp[i][4:0];
      case (row_kind[i])
         // Register writes never look like reads on idb
         chk_none: expect_equal("reading during register write", saw_reading, 0);
         chk_disp: expect_equal("dp_n", dp_n, want_disp);
         chk_stat: begin
            expect_equal("stat_4_3", stat_4_3, row_exp[i][4:3]);
            expect_equal("idb status bits", idb[11:8], row_exp[i][3:0]);
         end
         chk_msg: begin
            expect_equal("reading during register read", saw_reading, 1);
            expect_equal("idb message", idb[7:0], row_exp[i]);
         end
         chk_cal: begin
            expect_equal("reading during register read", saw_reading, 1);
            expect_equal("calendar register", idb[7:0],
                         cal_value(row_exp[i], edges_total));
         end
         chk_bus:  check_bus(row_exp[i][1], row_exp[i][0], row_cmd[i][3:0]);
         default: ;
      endcase
   endtask

   // Watchdog
   initial begin
      #(limit_cycles * 40);
      $display("Timeout after %0d cycles, %0d errors so far", limit_cycles, errors);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      pa     = '0;
      emp_n  = 1'b0;
      ful_n  = 1'b1;
      val    = 1'b0;
      panosc = 1'b0;
      epans  = 1'b0;
      lfsr   = 32'he5a9_4501;
      edges_total = 0;
      checks = 0;
      errors = 0;
      n_used = 0;
      saw_reading = 1'b0;
      build_table();
      @(posedge arst_n);
      @(negedge ck);
      // Outputs straight out of reset
      expect_equal("rmm_n after reset", rmm_n, 1);
      expect_equal("dp_n after reset", dp_n, 'h1f);
      expect_equal("stat_4_3 after reset", stat_4_3, 0);
      expect_equal("idb after reset", idb, {1'b0, ful_n, 1'b0, val, 12'h000});
      for (int i = 0; i < n_used; i++) begin
         @(posedge ck);
         #5;
         apply_row(i);
         wait_idle();
         check_row(i);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: verilog/calendar_rtc.sv
`timescale 1ns/100ps

module calendar_rtc
   import pancal_types_pkg::*, pancal_map_pkg::*;
#(
   parameter int ticks_per_sec = 50
) (
   input  logic      ck,
   input  logic      arst_n,
   input  logic      panosc,
   // Wishbone master 1
   output logic      m1_cyc,
   output logic      m1_stb,
   output logic      m1_we,
   output reg_addr_t m1_adr,
   output byte_t     m1_dat_w,
   input  byte_t     m1_dat_r,
   input  logic      m1_ack
);

   localparam int tick_w = $clog2(ticks_per_sec + 1);
   localparam logic [tick_w-1:0] last_tick = tick_w'(ticks_per_sec - 1);

   // Oscillator sync and edge detect
   logic osc_s1;
   logic osc_s2;
   logic osc_d;
   logic osc_rise;

   // Time of day
   logic [tick_w-1:0] tick_cnt;
   logic [5:0]        sec;
   logic [5:0]        mins;
   logic [4:0]        hour;
   byte_t             day;

   // Post control
   rtc_state_t state;
   logic [1:0] post_idx;
   logic       post_req;

   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         osc_s1 <= 1'b0;
         osc_s2 <= 1'b0;
         osc_d  <= 1'b0;
      end else begin
         osc_s1 <= panosc;
         osc_s2 <= osc_s1;
         osc_d  <= osc_s2;
      end
   end

   assign osc_rise = osc_s2 & ~osc_d;

   // Divider and cascade, runs regardless of the post
   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         tick_cnt <= '0;
         sec      <= '0;
         mins     <= '0;
         hour     <= '0;
         day      <= '0;
      end else if (osc_rise) begin
         if (tick_cnt == last_tick) begin
            tick_cnt <= '0;
            sec      <= (sec == sec_max) ? '0 : sec + 6'd1;
            if (sec == sec_max) begin
               mins <= (mins == min_max) ? '0 : mins + 6'd1;
               if (mins == min_max) begin
                  hour <= (hour == hour_max) ? '0 : hour + 5'd1;
                  if (hour == hour_max) begin
                     day <= day + 8'd1;
                  end
               end
            end
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // Post sequence, four writes with cyc dropped in between
   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         state    <= post_idle;
         post_idx <= '0;
         post_req <= 1'b0;
         m1_cyc   <= 1'b0;
         m1_stb   <= 1'b0;
      end else begin
         // New second, post again once the current one is done
         if (osc_rise && tick_cnt == last_tick) begin
            post_req <= 1'b1;
         end
         case (state)
            post_idle: begin
               if (post_req) begin
                  post_req <= 1'b0;
                  post_idx <= '0;
                  m1_cyc   <= 1'b1;
                  m1_stb   <= 1'b1;
                  state    <= post_write;
               end
            end
            post_write: begin
               if (m1_ack) begin
                  m1_cyc <= 1'b0;
                  m1_stb <= 1'b0;
                  state  <= (post_idx == post_last) ? post_idle : post_gap;
                  post_idx <= post_idx + 2'd1;
               end
            end
            post_gap: begin
               m1_cyc <= 1'b1;
               m1_stb <= 1'b1;
               state  <= post_write;
            end
            default: state <= post_idle;
         endcase
      end
   end

   // Data follows the live counters until the write lands
   always_comb begin
      case (post_idx)
         2'd0:    m1_dat_w = byte_t'(sec);
         2'd1:    m1_dat_w = byte_t'(mins);
         2'd2:    m1_dat_w = byte_t'(hour);
         default: m1_dat_w = day;
      endcase
   end

   assign m1_adr = rtc_base_addr + reg_addr_t'(post_idx);
   assign m1_we  = m1_cyc;

   // Register file echoes the byte it stored on the edge before ack
   a_write_echo: assert property (
      @(posedge ck) disable iff (!arst_n) m1_ack |-> (m1_dat_r == $past(m1_dat_w))
   );

endmodule

// File: verilog/io_pancal.sv
`timescale 1ns/100ps

module io_pancal
   import pancal_types_pkg::*;
#(
   parameter int ticks_per_sec = 50
) (
   input  logic        ck,
   input  logic        arst_n,
   // FIFO side
   input  byte_t       pa,
   input  logic        emp_n,
   input  logic        ful_n,
   input  logic        val,
   output logic        rmm_n,
   // Panel oscillator
   input  logic        panosc,
   // CPU bus enable, active low
   input  logic        epans,
   output word_t       idb,
   output disp_t       dp_n,
   output logic [1:0]  stat_4_3
);

   // Master 0
   logic      m0_cyc;
   logic      m0_stb;
   logic      m0_we;
   reg_addr_t m0_adr;
   byte_t     m0_dat_w;
   byte_t     m0_dat_r;
   logic      m0_ack;

   // Master 1
   logic      m1_cyc;
   logic      m1_stb;
   logic      m1_we;
   reg_addr_t m1_adr;
   byte_t     m1_dat_w;
   byte_t     m1_dat_r;
   logic      m1_ack;

   // Slave side
   logic      s_cyc;
   logic      s_stb;
   logic      s_we;
   reg_addr_t s_adr;
   byte_t     s_dat_w;
   byte_t     s_dat_r;
   logic      s_ack;

   // Panel results
   disp_t disp;
   stat_t stat;
   byte_t msg;
   logic  busy;
   logic  reading;

   panel_proc u_panel_proc (
      .ck(ck), .arst_n(arst_n),
      .pa(pa), .emp_n(emp_n), .rmm_n(rmm_n),
      .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
      .m0_dat_w(m0_dat_w), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
      .disp(disp), .stat(stat), .msg(msg), .busy(busy), .reading(reading)
   );

   calendar_rtc #(.ticks_per_sec(ticks_per_sec)) u_calendar_rtc (
      .ck(ck), .arst_n(arst_n), .panosc(panosc),
      .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
      .m1_dat_w(m1_dat_w), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack)
   );

   wb_arbiter u_wb_arbiter (
      .ck(ck), .arst_n(arst_n),
      .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
      .m0_dat_w(m0_dat_w), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
      .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
      .m1_dat_w(m1_dat_w), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack),
      .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
      .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
   );

   pancal_regfile u_pancal_regfile (
      .ck(ck), .arst_n(arst_n),
      .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
      .dat_w(s_dat_w), .dat_r(s_dat_r), .ack(s_ack)
   );

   // Display lines leave inverted
   assign dp_n     = ~disp;
   assign stat_4_3 = stat[4:3];

   // Bus word only while the CPU selects the panel
   assign idb = epans ? '0 : {busy, ful_n, reading, val, stat[3:0], msg};

endmodule

// File: verilog/pancal_map_pkg.sv
package pancal_map_pkg;

   // Opcodes in command bits 7:6
   localparam logic [1:0] op_disp = 2'd0;
   localparam logic [1:0] op_stat = 2'd1;
   localparam logic [1:0] op_wreg = 2'd2;
   localparam logic [1:0] op_rreg = 2'd3;

   // Calendar occupies the top four registers
   // Seconds at base, then minutes, hours, day
   localparam logic [3:0] rtc_base_addr = 4'd12;

   // Wrap limits for the time of day
   localparam logic [5:0] sec_max  = 6'd59;
   localparam logic [5:0] min_max  = 6'd59;
   localparam logic [4:0] hour_max = 5'd23;

   // Index of the last calendar write in a post
   localparam logic [1:0] post_last = 2'd3;

endpackage

// File: verilog/pancal_regfile.sv
`timescale 1ns/100ps

module pancal_regfile
   import pancal_types_pkg::*;
(
   input  logic      ck,
   input  logic      arst_n,
   input  logic      cyc,
   input  logic      stb,
   input  logic      we,
   input  reg_addr_t adr,
   input  byte_t     dat_w,
   output byte_t     dat_r,
   output logic      ack
);

   // Panel bytes 0 to 11, calendar bytes 12 to 15
   byte_t mem [16];

   logic req;

   // New request only when no ack is already out
   assign req = cyc & stb & ~ack;

   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 16; i++) begin
            mem[i] <= '0;
         end
      end else if (req && we) begin
         mem[adr] <= dat_w;
      end
   end

   // Read data, echoes the written byte on a write
   always_ff @(posedge ck) begin
      if (req) begin
         dat_r <= we ? dat_w : mem[adr];
      end
   end

   // Masters hold stb until they see ack
   a_ack_with_stb: assert property (
      @(posedge ck) disable iff (!arst_n) ack |-> (cyc && stb)
   );

endmodule

// File: verilog/pancal_types_pkg.sv
package pancal_types_pkg;

   // FIFO bytes and register file contents
   typedef logic [7:0] byte_t;

   // Internal data bus word toward the CPU
   typedef logic [15:0] word_t;

   // Register file has sixteen locations
   typedef logic [3:0] reg_addr_t;

   // Display lines, active high inside the block
   typedef logic [4:0] disp_t;

   // Status field, bits 4:3 also leave the board
   typedef logic [4:0] stat_t;

   // Panel processor command sequence
   typedef enum logic [2:0] {idle, strobe, decode, wait_data, bus} proc_state_t;

   // Calendar post sequence, one write per register
   typedef enum logic [1:0] {post_idle, post_write, post_gap} rtc_state_t;

endpackage

// File: verilog/panel_proc.sv
`timescale 1ns/100ps

module panel_proc
   import pancal_types_pkg::*, pancal_map_pkg::*;
(
   input  logic      ck,
   input  logic      arst_n,
   // FIFO side
   input  byte_t     pa,
   input  logic      emp_n,
   output logic      rmm_n,
   // Wishbone master 0
   output logic      m0_cyc,
   output logic      m0_stb,
   output logic      m0_we,
   output reg_addr_t m0_adr,
   output byte_t     m0_dat_w,
   input  byte_t     m0_dat_r,
   input  logic      m0_ack,
   // Decoded results
   output disp_t     disp,
   output stat_t     stat,
   output byte_t     msg,
   output logic      busy,
   output logic      reading
);

   proc_state_t state;

   // Current FIFO byte
   byte_t cmd;

   // Register write waiting for its data byte
   reg_addr_t wr_adr;
   logic      wr_pend;

   // Control sequence
   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         state   <= idle;
         rmm_n   <= 1'b1;
         m0_cyc  <= 1'b0;
         m0_stb  <= 1'b0;
         m0_we   <= 1'b0;
         disp    <= '0;
         stat    <= '0;
         msg     <= '0;
         wr_adr  <= '0;
         wr_pend <= 1'b0;
      end else begin
         case (state)
            idle: begin
               // Only fetch when the FIFO has a byte
               if (emp_n) begin
                  rmm_n <= 1'b0;
                  state <= strobe;
               end
            end
            strobe: begin
               // One cycle read pulse
               rmm_n <= 1'b1;
               state <= wait_data;
            end
            wait_data: begin
               // FIFO drives pa after the strobe, cmd takes it here
               state <= decode;
            end
            decode: begin
               if (wr_pend) begin
                  // Second byte of op_wreg is the data
                  wr_pend <= 1'b0;
                  if (wr_adr < rtc_base_addr) begin
                     m0_cyc <= 1'b1;
                     m0_stb <= 1'b1;
                     m0_we  <= 1'b1;
                     state  <= bus;
                  end else begin
                     // Calendar registers are not writable from the panel
                     state <= idle;
                  end
               end else begin
                  case (cmd[7:6])
                     op_disp: begin
                        disp  <= cmd[4:0];
                        state <= idle;
                     end
                     op_stat: begin
                        stat  <= cmd[4:0];
                        state <= idle;
                     end
                     op_wreg: begin
                        wr_adr  <= cmd[3:0];
                        wr_pend <= 1'b1;
                        state   <= idle;
                     end
                     op_rreg: begin
                        m0_cyc <= 1'b1;
                        m0_stb <= 1'b1;
                        m0_we  <= 1'b0;
                        state  <= bus;
                     end
                  endcase
               end
            end
            bus: begin
               // Hold the request until the slave answers
               if (m0_ack) begin
                  m0_cyc <= 1'b0;
                  m0_stb <= 1'b0;
                  if (!m0_we) begin
                     msg <= m0_dat_r;
                  end
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Command byte and bus payload
   always_ff @(posedge ck) begin
      if (state == wait_data) begin
         cmd <= pa;
      end
      if (state == decode) begin
         m0_adr   <= wr_pend ? wr_adr : cmd[3:0];
         m0_dat_w <= cmd;
      end
   end

   assign busy    = (state != idle);
   assign reading = m0_cyc & ~m0_we;

   // Ack through the arbiter only while this master waits on the bus
   a_ack_in_bus: assert property (
      @(posedge ck) disable iff (!arst_n) m0_ack |-> (state == bus)
   );

endmodule

// File: verilog/wb_arbiter.sv
`timescale 1ns/100ps

module wb_arbiter
   import pancal_types_pkg::*;
(
   input  logic      ck,
   input  logic      arst_n,
   // Master 0, panel processor
   input  logic      m0_cyc,
   input  logic      m0_stb,
   input  logic      m0_we,
   input  reg_addr_t m0_adr,
   input  byte_t     m0_dat_w,
   output byte_t     m0_dat_r,
   output logic      m0_ack,
   // Master 1, calendar
   input  logic      m1_cyc,
   input  logic      m1_stb,
   input  logic      m1_we,
   input  reg_addr_t m1_adr,
   input  byte_t     m1_dat_w,
   output byte_t     m1_dat_r,
   output logic      m1_ack,
   // Toward the register file
   output logic      s_cyc,
   output logic      s_stb,
   output logic      s_we,
   output reg_addr_t s_adr,
   output byte_t     s_dat_w,
   input  byte_t     s_dat_r,
   input  logic      s_ack
);

   // Grant valid and the owner bit that remembers the last master
   logic gnt;
   logic owner;
   logic own_cyc;

   assign own_cyc = owner ? m1_cyc : m0_cyc;

   always_ff @(posedge ck or negedge arst_n) begin
      if (!arst_n) begin
         gnt   <= 1'b0;
         owner <= 1'b1;
      end else if (gnt) begin
         // Release when the owner ends its cycle
         if (!own_cyc) begin
            gnt <= 1'b0;
         end
      end else if (m0_cyc || m1_cyc) begin
         // The master that did not own last goes first
         gnt   <= 1'b1;
         owner <= owner ? !m0_cyc : m1_cyc;
      end
   end

   assign s_cyc   = gnt & own_cyc;
   assign s_stb   = gnt & (owner ? m1_stb : m0_stb);
   assign s_we    = owner ? m1_we : m0_we;
   assign s_adr   = owner ? m1_adr : m0_adr;
   assign s_dat_w = owner ? m1_dat_w : m0_dat_w;

   // Shared read data
   assign m0_dat_r = s_dat_r;
   assign m1_dat_r = s_dat_r;

   // Ack goes to the owner only
   assign m0_ack   = gnt & ~owner & s_ack;
   assign m1_ack   = gnt & owner & s_ack;

   // An open slave cycle keeps its master and request until the ack
   a_grant_hold: assert property (
      @(posedge ck) disable iff (!arst_n)
         (s_cyc && !s_ack) |=> (s_cyc && $stable(owner) && $stable(s_adr) && $stable(s_we))
   );

endmodule
